// ==== source/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// ********************
	// bus geometry
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 64;
	localparam int STRB_W     = DATA_W / 8;
	localparam int PC_W       = 64;
	localparam int INST_W     = 32;
	// sram holds 64-bit words, indexed by addr[12:3]
	localparam int SRAM_DEPTH = 1024;
	localparam int SRAM_AW    = $clog2(SRAM_DEPTH);

	// access size of a load or store
	typedef enum logic [1:0] {
		SIZE_B = 2'd0,
		SIZE_H = 2'd1,
		SIZE_W = 2'd2,
		SIZE_D = 2'd3
	} size_e;

	// ********************
	// shared memory bus, one-cycle request/response
	typedef struct packed {
		logic              req;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
	} mem_req_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] rdata;
	} mem_rsp_t;

	// external load/store request
	typedef struct packed {
		logic              we;
		size_e             size;
		logic              sext;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} lsu_req_t;

	// one fetched instruction
	typedef struct packed {
		logic [PC_W-1:0]   pc;
		logic [INST_W-1:0] inst;
	} fetch_t;

endpackage

`default_nettype wire

// ==== source/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

	localparam int MUL_W = 64;

	// start-to-done latency, iterations plus one output cycle
	localparam int MUL_LAT_D  = 34;
	localparam int MUL_LAT_W  = 18;
	localparam int MUL_ITER_D = MUL_LAT_D - 1;
	localparam int MUL_ITER_W = MUL_LAT_W - 1;
	localparam int MUL_CNT_W  = 6;

	typedef struct packed {
		logic             mulw;
		// [1] multiplicand signed, [0] multiplier signed
		logic [1:0]       mul_signed;
		logic [MUL_W-1:0] mulcand;
		logic [MUL_W-1:0] muler;
	} mul_req_t;

	typedef struct packed {
		logic [MUL_W-1:0] result_hi;
		logic [MUL_W-1:0] result_lo;
	} mul_rsp_t;

endpackage

`default_nettype wire

// ==== source/mem_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sram (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::mem_req_t req,
	output mem_pkg::mem_rsp_t rsp
);

	logic [mem_pkg::DATA_W-1:0]  mem_q [mem_pkg::SRAM_DEPTH];
	logic [mem_pkg::SRAM_AW-1:0] idx;

	// word index, upper address bits ignored
	assign idx = req.addr[mem_pkg::SRAM_AW+2:3];

	// byte-lane write
	always_ff @(posedge clk) begin
		if (req.req && req.we) begin
			for (int i = 0; i < mem_pkg::STRB_W; i++) begin
				if (req.wstrb[i])
					mem_q[idx][i*8 +: 8] <= req.wdata[i*8 +: 8];
			end
		end
	end

	// response one cycle after the request
	always_ff @(posedge clk) begin
		if (rst)
			rsp.valid <= 1'b0;
		else
			rsp.valid <= req.req;
	end

	// writes answer with zero data
	always_ff @(posedge clk) begin
		if (req.req)
			rsp.rdata <= req.we ? '0 : mem_q[idx];
	end

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::mem_req_t lsu_req,
	input  mem_pkg::mem_req_t ifu_req,
	output mem_pkg::mem_req_t mem_req,
	input  mem_pkg::mem_rsp_t mem_rsp,
	output mem_pkg::mem_rsp_t lsu_rsp,
	output mem_pkg::mem_rsp_t ifu_rsp,
	output logic              ifu_gnt
);

	// owner of the request now in the sram
	logic lsu_own_q;
	logic ifu_own_q;

	// ********************
	// fixed priority, lsu first
	assign mem_req = lsu_req.req ? lsu_req : ifu_req;
	assign ifu_gnt = ifu_req.req && !lsu_req.req;

	always_ff @(posedge clk) begin
		if (rst) begin
			lsu_own_q <= 1'b0;
			ifu_own_q <= 1'b0;
		end else begin
			lsu_own_q <= lsu_req.req;
			ifu_own_q <= ifu_gnt;
		end
	end

	// ********************
	// response steering
	// valid goes to the owner only, data fans out to both
	assign lsu_rsp.valid = mem_rsp.valid && lsu_own_q;
	assign lsu_rsp.rdata = mem_rsp.rdata;
	assign ifu_rsp.valid = mem_rsp.valid && ifu_own_q;
	assign ifu_rsp.rdata = mem_rsp.rdata;

	// never both ports at once
	a_rsp_onehot: assert property (@(posedge clk) disable iff (rst)
		!(lsu_rsp.valid && ifu_rsp.valid));

	// sram answers only what was issued the cycle before
	a_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
		mem_rsp.valid |-> $past(mem_req.req));

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fetch_en,
	input  logic                      redirect_valid,
	input  logic [mem_pkg::PC_W-1:0]  redirect_pc,
	output mem_pkg::mem_req_t         mem_req,
	input  logic                      gnt,
	input  mem_pkg::mem_rsp_t         mem_rsp,
	output logic                      fetch_valid,
	output mem_pkg::fetch_t           fetch
);

	// next pc to request
	logic [mem_pkg::PC_W-1:0] pc_q;
	// flips on each redirect
	logic                     epoch_q;
	// granted fetch waiting for its word
	logic                     slot_v_q;
	logic [mem_pkg::PC_W-1:0] slot_pc_q;
	logic                     slot_tag_q;
	logic                     take;

	// read-only request, held until granted
	always_comb begin
		mem_req       = '0;
		mem_req.req   = fetch_en;
		mem_req.addr  = pc_q[mem_pkg::ADDR_W-1:0];
	end

	// keep the word only if it belongs to the current epoch
	// and no redirect is arriving right now
	assign take = mem_rsp.valid && slot_v_q && (slot_tag_q == epoch_q) && !redirect_valid;

	// ********************
	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q        <= '0;
			epoch_q     <= 1'b0;
			slot_v_q    <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			slot_v_q    <= gnt;
			fetch_valid <= take;
			if (redirect_valid) begin
				pc_q    <= redirect_pc;
				epoch_q <= ~epoch_q;
			end else if (gnt) begin
				pc_q    <= pc_q + 64'd4;
			end
		end
	end

	// ********************
	// in-flight pc and output
	always_ff @(posedge clk) begin
		if (gnt) begin
			slot_pc_q  <= pc_q;
			// tag with the epoch before any redirect this cycle
			slot_tag_q <= epoch_q;
		end
		if (take) begin
			fetch.pc   <= slot_pc_q;
			// pc[2] picks the half of the 64-bit word
			fetch.inst <= slot_pc_q[2] ? mem_rsp.rdata[63:32] : mem_rsp.rdata[31:0];
		end
	end

	// redirect drops whatever is in flight
	a_no_fetch_after_redirect: assert property (@(posedge clk) disable iff (rst)
		redirect_valid |=> !fetch_valid);

endmodule

`default_nettype wire

// ==== source/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        req_valid,
	input  mem_pkg::lsu_req_t           req,
	output mem_pkg::mem_req_t           mem_req,
	input  mem_pkg::mem_rsp_t           mem_rsp,
	output logic                        rsp_valid,
	output logic [mem_pkg::DATA_W-1:0]  rdata
);

	mem_pkg::lsu_req_t          req_q;
	// issue cycle strobe
	logic                       issue_q;
	// set from request until response
	logic                       out_q;
	logic [mem_pkg::STRB_W-1:0] strb;
	logic [mem_pkg::DATA_W-1:0] shifted;
	logic [3:0]                 align_span;

	// ********************
	// request register
	always_ff @(posedge clk) begin
		if (rst) begin
			issue_q <= 1'b0;
			out_q   <= 1'b0;
		end else begin
			issue_q <= req_valid;
			if (req_valid)
				out_q <= 1'b1;
			else if (mem_rsp.valid)
				out_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid)
			req_q <= req;
	end

	// strobe for the size, shifted to the byte offset
	always_comb begin
		case (req_q.size)
			mem_pkg::SIZE_B: strb = 8'h01 << req_q.addr[2:0];
			mem_pkg::SIZE_H: strb = 8'h03 << req_q.addr[2:0];
			mem_pkg::SIZE_W: strb = 8'h0f << req_q.addr[2:0];
			default:         strb = 8'hff;
		endcase
	end

	always_comb begin
		mem_req       = '0;
		mem_req.req   = issue_q;
		mem_req.we    = req_q.we;
		mem_req.addr  = req_q.addr;
		// store data into its byte lane
		mem_req.wdata = req_q.wdata << {req_q.addr[2:0], 3'b000};
		mem_req.wstrb = req_q.we ? strb : '0;
	end

	// ********************
	// load return
	assign rsp_valid = mem_rsp.valid && out_q;
	assign shifted   = mem_rsp.rdata >> {req_q.addr[2:0], 3'b000};

	// field extract, then sign or zero extend
	always_comb begin
		case (req_q.size)
			mem_pkg::SIZE_B: rdata = {{56{req_q.sext & shifted[7]}}, shifted[7:0]};
			mem_pkg::SIZE_H: rdata = {{48{req_q.sext & shifted[15]}}, shifted[15:0]};
			mem_pkg::SIZE_W: rdata = {{32{req_q.sext & shifted[31]}}, shifted[31:0]};
			default:         rdata = shifted;
		endcase
	end

	// low address bits that must be zero for this size
	assign align_span = (4'd1 << req.size) - 4'd1;

	a_aligned: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> (req.addr[2:0] & align_span[2:0]) == 3'b000);

	// one access at a time, a new one may meet the response
	a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> !out_q || mem_rsp.valid);

endmodule

`default_nettype wire

// ==== source/booth_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module booth_mul (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              flush,
	input  mul_pkg::mul_req_t req,
	output logic              busy,
	output logic              done,
	output mul_pkg::mul_rsp_t rsp
);

	logic                          busy_q;
	logic                          mulw_q;
	logic [mul_pkg::MUL_CNT_W-1:0] cnt_q;
	// multiplicand, one extra bit for signedness
	logic [64:0]                   mcand_q;
	// shifting product, hi accumulates, lo holds multiplier bits
	logic [65:0]                   hi_q;
	logic [65:0]                   lo_q;
	// booth bit below lo[0]
	logic                          q_q;
	logic [64:0]                   mcand_ext;
	logic [65:0]                   muler_ext;
	logic [67:0]                   pp;
	logic [67:0]                   sum;
	logic [131:0]                  prod;
	logic [63:0]                   prod_w;

	// ********************
	// operand extension
	always_comb begin
		if (req.mulw) begin
			// word mode, low 32 bits only
			mcand_ext = {{33{req.mul_signed[1] & req.mulcand[31]}}, req.mulcand[31:0]};
			muler_ext = {{34{req.mul_signed[0] & req.muler[31]}}, req.muler[31:0]};
		end else begin
			mcand_ext = {req.mul_signed[1] & req.mulcand[63], req.mulcand};
			muler_ext = {{2{req.mul_signed[0] & req.muler[63]}}, req.muler};
		end
	end

	// ********************
	// radix-4 booth digit
	always_comb begin
		case ({lo_q[1:0], q_q})
			// +1
			3'b001, 3'b010: pp = {{3{mcand_q[64]}}, mcand_q};
			// +2
			3'b011:         pp = {{2{mcand_q[64]}}, mcand_q, 1'b0};
			// -2
			3'b100:         pp = -{{2{mcand_q[64]}}, mcand_q, 1'b0};
			// -1
			3'b101, 3'b110: pp = -{{3{mcand_q[64]}}, mcand_q};
			default:        pp = '0;
		endcase
	end

	assign sum = {{2{hi_q[65]}}, hi_q} + pp;

	// ********************
	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (flush) begin
			busy_q <= 1'b0;
		end else if (start) begin
			busy_q <= 1'b1;
			cnt_q  <= req.mulw ? mul_pkg::MUL_CNT_W'(mul_pkg::MUL_ITER_W)
			                   : mul_pkg::MUL_CNT_W'(mul_pkg::MUL_ITER_D);
		end else if (busy_q) begin
			// zero count is the output cycle
			if (cnt_q == '0)
				busy_q <= 1'b0;
			else
				cnt_q <= cnt_q - 1'b1;
		end
	end

	// datapath, two multiplier bits per cycle
	always_ff @(posedge clk) begin
		if (start) begin
			mcand_q <= mcand_ext;
			mulw_q  <= req.mulw;
			hi_q    <= '0;
			lo_q    <= muler_ext;
			q_q     <= 1'b0;
		end else if (busy_q && cnt_q != '0) begin
			// add, then arithmetic shift right by two
			hi_q <= sum[67:2];
			lo_q <= {sum[1:0], lo_q[65:2]};
			q_q  <= lo_q[1];
		end
	end

	// ********************
	// result
	assign prod   = {hi_q, lo_q};
	// word mode stops 16 iterations early, product sits at bit 32
	assign prod_w = prod[95:32];

	always_comb begin
		if (mulw_q) begin
			rsp.result_hi = {{32{prod_w[63]}}, prod_w[63:32]};
			rsp.result_lo = {{32{prod_w[31]}}, prod_w[31:0]};
		end else begin
			rsp.result_hi = prod[127:64];
			rsp.result_lo = prod[63:0];
		end
	end

	assign busy = busy_q;
	assign done = busy_q && (cnt_q == '0) && !flush;

	a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
		start |-> !busy_q);

endmodule

`default_nettype wire

// ==== source/npc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_mem_top (
	input  logic                        clk,
	input  logic                        rst,
	// fetch
	input  logic                        fetch_en,
	input  logic                        redirect_valid,
	input  logic [mem_pkg::PC_W-1:0]    redirect_pc,
	output logic                        fetch_valid,
	output mem_pkg::fetch_t             fetch,
	// load/store
	input  logic                        lsu_req_valid,
	input  mem_pkg::lsu_req_t           lsu_req,
	output logic                        lsu_rsp_valid,
	output logic [mem_pkg::DATA_W-1:0]  lsu_rdata,
	// multiplier
	input  logic                        mul_start,
	input  logic                        mul_flush,
	input  mul_pkg::mul_req_t           mul_req,
	output logic                        mul_done,
	output mul_pkg::mul_rsp_t           mul_rsp
);

	// ********************
	// memory side wiring
	mem_pkg::mem_req_t ifu_mreq;
	mem_pkg::mem_rsp_t ifu_mrsp;
	mem_pkg::mem_req_t lsu_mreq;
	mem_pkg::mem_rsp_t lsu_mrsp;
	mem_pkg::mem_req_t sram_req;
	mem_pkg::mem_rsp_t sram_rsp;
	logic              ifu_gnt;

	fetch_unit u_ifu (
		.clk            (clk),
		.rst            (rst),
		.fetch_en       (fetch_en),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.mem_req        (ifu_mreq),
		.gnt            (ifu_gnt),
		.mem_rsp        (ifu_mrsp),
		.fetch_valid    (fetch_valid),
		.fetch          (fetch)
	);

	lsu u_lsu (
		.clk       (clk),
		.rst       (rst),
		.req_valid (lsu_req_valid),
		.req       (lsu_req),
		.mem_req   (lsu_mreq),
		.mem_rsp   (lsu_mrsp),
		.rsp_valid (lsu_rsp_valid),
		.rdata     (lsu_rdata)
	);

	// lsu has priority over fetch
	mem_arbiter u_arb (
		.clk     (clk),
		.rst     (rst),
		.lsu_req (lsu_mreq),
		.ifu_req (ifu_mreq),
		.mem_req (sram_req),
		.mem_rsp (sram_rsp),
		.lsu_rsp (lsu_mrsp),
		.ifu_rsp (ifu_mrsp),
		.ifu_gnt (ifu_gnt)
	);

	mem_sram u_sram (
		.clk (clk),
		.rst (rst),
		.req (sram_req),
		.rsp (sram_rsp)
	);

	// ********************
	// multiplier, busy only used internally
	booth_mul u_mul (
		.clk   (clk),
		.rst   (rst),
		.start (mul_start),
		.flush (mul_flush),
		.req   (mul_req),
		.busy  (),
		.done  (mul_done),
		.rsp   (mul_rsp)
	);

endmodule

`default_nettype wire

// ==== dv/tb_npc_stim.svh ====
`ifndef TB_NPC_STIM_SVH
`define TB_NPC_STIM_SVH
`default_nettype none

// ********************
// driver tasks
// one load/store, returns once its response is seen
task automatic lsu_access(input logic we, input mem_pkg::size_e size, input logic sext,
		input logic [31:0] addr, input logic [63:0] wdata);
	int n;
	n = 1 << size;
	@(posedge clk);
	lsu_req_valid <= 1'b1;
	lsu_req.we    <= we;
	lsu_req.size  <= size;
	lsu_req.sext  <= sext;
	lsu_req.addr  <= addr;
	lsu_req.wdata <= wdata;
	if (we) begin
		// model takes the store at issue
		for (int i = 0; i < n; i++)
			mem_model[addr[12:0] + i] = wdata[i*8 +: 8];
		exp_lsu_rdata <= '0;
	end else begin
		exp_lsu_rdata <= load_field(addr, size, sext);
	end
	@(posedge clk);
	lsu_req_valid <= 1'b0;
	do
		@(negedge clk);
	while (!lsu_rsp_valid);
endtask

task automatic wait_fetches(input int n);
	int target;
	target = fetch_cnt + n;
	while (fetch_cnt < target)
		@(negedge clk);
endtask

// start strobe, caller is just past a rising edge
task automatic issue_multiply(input logic mulw, input logic [1:0] sgn,
		input logic [63:0] a, input logic [63:0] b);
	mul_start          <= 1'b1;
	mul_req.mulw       <= mulw;
	mul_req.mul_signed <= sgn;
	mul_req.mulcand    <= a;
	mul_req.muler      <= b;
	exp_mul_rsp        <= mul_expect(mulw, sgn, a, b);
	@(posedge clk);
	mul_start <= 1'b0;
endtask

task automatic run_multiply(input logic mulw, input logic [1:0] sgn,
		input logic [63:0] a, input logic [63:0] b);
	@(posedge clk);
	issue_multiply(mulw, sgn, a, b);
	do
		@(negedge clk);
	while (!mul_done);
endtask

task automatic report_test(input string name);
	test_cnt++;
	$display("test %0d %s finished at %0t ns, failures so far %0d", test_cnt, name, $time,
		err_cnt);
endtask

// ********************
// tests
// each size stored inside one double, then read back every way
task automatic lsu_size_sweep();
	logic [31:0] base;
	logic [31:0] addr [4];
	for (int r = 0; r < 4; r++) begin
		base    = DATA_BASE + (($urandom % 512) << 3);
		addr[3] = base;
		addr[0] = base + ($urandom % 8);
		addr[1] = base + (($urandom % 4) << 1);
		addr[2] = base + (($urandom % 2) << 2);
		for (int s = 3; s >= 0; s--)
			lsu_access(1'b1, mem_pkg::size_e'(s), 1'b0, addr[s], {$urandom, $urandom});
		for (int s = 0; s < 4; s++) begin
			lsu_access(1'b0, mem_pkg::size_e'(s), 1'b0, addr[s], '0);
			lsu_access(1'b0, mem_pkg::size_e'(s), 1'b1, addr[s], '0);
		end
	end
	report_test("load/store sizes");
endtask

// code preload, then a straight run from pc 0
task automatic fetch_sequence();
	for (int i = 0; i < CODE_WORDS; i++)
		lsu_access(1'b1, mem_pkg::SIZE_D, 1'b0, i * 8, {$urandom, $urandom});
	@(posedge clk);
	fetch_en <= 1'b1;
	wait_fetches(24);
	@(posedge clk);
	fetch_en <= 1'b0;
	report_test("sequential fetch");
endtask

// data traffic steals the bus from a running fetch
task automatic arbitration_mix();
	logic [31:0] a;
	@(posedge clk);
	fetch_en <= 1'b1;
	for (int i = 0; i < 12; i++) begin
		a = DATA_BASE + (($urandom % 512) << 3);
		lsu_access(1'b1, mem_pkg::SIZE_D, 1'b0, a, {$urandom, $urandom});
		lsu_access(1'b0, mem_pkg::size_e'($urandom % 4), 1'($urandom % 2), a, '0);
	end
	report_test("arbitration");
endtask

// fetch_en still high from the previous test
task automatic redirect_flow();
	logic [63:0] target;
	for (int k = 0; k < 2; k++) begin
		target = 64'(($urandom % 256) << 2);
		wait_fetches(4);
		@(posedge clk);
		redirect_valid <= 1'b1;
		redirect_pc    <= target;
		@(posedge clk);
		redirect_valid <= 1'b0;
		wait_fetches(12);
	end
	@(posedge clk);
	fetch_en <= 1'b0;
	report_test("redirect");
endtask

task automatic multiply_modes();
	logic [63:0] min_v;
	for (int w = 0; w < 2; w++) begin
		// most negative value of the mode
		min_v = w[0] ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
		for (int s = 0; s < 4; s++) begin
			run_multiply(w[0], s[1:0], {$urandom, $urandom}, {$urandom, $urandom});
			run_multiply(w[0], s[1:0], {$urandom, $urandom}, {$urandom, $urandom});
			run_multiply(w[0], s[1:0], min_v, min_v);
			run_multiply(w[0], s[1:0], min_v, '1);
			run_multiply(w[0], s[1:0], '0, {$urandom, $urandom});
		end
	end
	report_test("multiply modes");
endtask

// flush mid-operation, restart on the next edge
task automatic flush_restart();
	for (int k = 0; k < 3; k++) begin
		run_flushed:
		begin
			@(posedge clk);
			issue_multiply(1'b0, 2'b11, {$urandom, $urandom}, {$urandom, $urandom});
			repeat (5 + $urandom % 20) @(posedge clk);
			mul_flush <= 1'b1;
			@(posedge clk);
			mul_flush <= 1'b0;
			issue_multiply(1'($urandom % 2), 2'($urandom % 4), {$urandom, $urandom},
				{$urandom, $urandom});
			do
				@(negedge clk);
			while (!mul_done);
		end
	end
	report_test("multiply flush");
endtask

`default_nettype wire
`endif

// ==== dv/tb_npc_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_npc_mem;

	// ********************
	// memory map and run length
	localparam int CODE_WORDS = 256;
	localparam int DATA_BASE  = 32'h1000;
	// rough cycles per test
	localparam int T_LSU      = 4 * 12 * 5;
	localparam int T_FETCH    = CODE_WORDS * 5 + 64;
	localparam int T_ARB      = 12 * 2 * 5 + 64;
	localparam int T_REDIR    = 2 * 32;
	localparam int T_MUL      = 40 * (mul_pkg::MUL_LAT_D + 4);
	localparam int T_FLUSH    = 3 * (2 * mul_pkg::MUL_LAT_D + 8);
	localparam int MAX_CYCLES = T_LSU + T_FETCH + T_ARB + T_REDIR + T_MUL + T_FLUSH + 1000;

	logic                       clk;
	logic                       rst;
	logic                       fetch_en;
	logic                       redirect_valid;
	logic [63:0]                redirect_pc;
	logic                       fetch_valid;
	mem_pkg::fetch_t            fetch;
	logic                       lsu_req_valid;
	mem_pkg::lsu_req_t          lsu_req;
	logic                       lsu_rsp_valid;
	logic [63:0]                lsu_rdata;
	logic                       mul_start;
	logic                       mul_flush;
	mul_pkg::mul_req_t          mul_req;
	logic                       mul_done;
	mul_pkg::mul_rsp_t          mul_rsp;

	// reference models
	logic [7:0]                 mem_model [8192];
	logic [63:0]                exp_lsu_rdata;
	logic [63:0]                exp_fetch_pc;
	mul_pkg::mul_rsp_t          exp_mul_rsp;
	// multiply in flight, age counts edges since start
	logic                       mul_pending;
	logic [7:0]                 mul_age;
	logic [7:0]                 mul_lat;
	int                         err_cnt;
	int                         test_cnt;
	int                         lsu_cnt;
	int                         fetch_cnt;
	int                         mul_cnt;
	int                         cycles;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	npc_mem_top u_dut (
		.clk            (clk),
		.rst            (rst),
		.fetch_en       (fetch_en),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.fetch_valid    (fetch_valid),
		.fetch          (fetch),
		.lsu_req_valid  (lsu_req_valid),
		.lsu_req        (lsu_req),
		.lsu_rsp_valid  (lsu_rsp_valid),
		.lsu_rdata      (lsu_rdata),
		.mul_start      (mul_start),
		.mul_flush      (mul_flush),
		.mul_req        (mul_req),
		.mul_done       (mul_done),
		.mul_rsp        (mul_rsp)
	);

	// ********************
	// model helpers
	function automatic logic [31:0] code_word(input logic [63:0] pc);
		logic [12:0] a;
		a = pc[12:0];
		return {mem_model[a + 3], mem_model[a + 2], mem_model[a + 1], mem_model[a]};
	endfunction

	// field of 1, 2, 4 or 8 bytes, then extended
	function automatic logic [63:0] load_field(input logic [31:0] addr,
			input mem_pkg::size_e size, input logic sext);
		logic [63:0] v;
		int          n;
		n = 1 << size;
		v = '0;
		for (int i = 0; i < n; i++)
			v[i*8 +: 8] = mem_model[addr[12:0] + i];
		if (sext && n < 8 && v[n*8-1])
			v = v | ~((64'd1 << (n * 8)) - 64'd1);
		return v;
	endfunction

	// full product in 130-bit signed arithmetic
	function automatic mul_pkg::mul_rsp_t mul_expect(input logic mulw, input logic [1:0] sgn,
			input logic [63:0] a, input logic [63:0] b);
		logic signed [129:0] wa;
		logic signed [129:0] wb;
		logic signed [129:0] p;
		mul_pkg::mul_rsp_t   r;
		if (mulw) begin
			wa = $signed({{98{sgn[1] & a[31]}}, a[31:0]});
			wb = $signed({{98{sgn[0] & b[31]}}, b[31:0]});
		end else begin
			wa = $signed({{66{sgn[1] & a[63]}}, a});
			wb = $signed({{66{sgn[0] & b[63]}}, b});
		end
		p = wa * wb;
		if (mulw) begin
			r.result_hi = {{32{p[63]}}, p[63:32]};
			r.result_lo = {{32{p[31]}}, p[31:0]};
		end else begin
			r.result_hi = p[127:64];
			r.result_lo = p[63:0];
		end
		return r;
	endfunction

	task automatic note_failure(input string msg);
		err_cnt++;
		$display("Fail at %0t ns: %s", $time, msg);
	endtask

	// ********************
	// trackers
	// expected pc restarts at each redirect
	always @(posedge clk) begin
		if (rst)
			exp_fetch_pc <= '0;
		else if (redirect_valid)
			exp_fetch_pc <= redirect_pc;
		else if (fetch_valid)
			exp_fetch_pc <= exp_fetch_pc + 64'd4;
	end

	always @(posedge clk) begin
		if (rst || mul_flush) begin
			mul_pending <= 1'b0;
			mul_age     <= '0;
		end else if (mul_start) begin
			mul_pending <= 1'b1;
			mul_age     <= 8'd1;
			mul_lat     <= mul_req.mulw ? 8'(mul_pkg::MUL_LAT_W) : 8'(mul_pkg::MUL_LAT_D);
		end else if (mul_pending) begin
			mul_age <= mul_age + 8'd1;
			if (mul_done)
				mul_pending <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (fetch_valid)
				fetch_cnt <= fetch_cnt + 1;
			if (lsu_rsp_valid)
				lsu_cnt <= lsu_cnt + 1;
			if (mul_done)
				mul_cnt <= mul_cnt + 1;
		end
	end

	// ********************
	// checks
	a_lsu_latency: assert property (@(posedge clk) disable iff (rst)
		lsu_req_valid |-> ##2 lsu_rsp_valid)
		else note_failure("load/store response missing 2 cycles after request");

	a_lsu_no_stray: assert property (@(posedge clk) disable iff (rst)
		lsu_rsp_valid |-> $past(lsu_req_valid, 2))
		else note_failure("load/store response without a request 2 cycles before");

	a_lsu_data: assert property (@(posedge clk) disable iff (rst)
		lsu_rsp_valid |-> lsu_rdata == exp_lsu_rdata)
		else note_failure($sformatf("lsu_rdata %h, expected %h", lsu_rdata, exp_lsu_rdata));

	a_fetch_pc: assert property (@(posedge clk) disable iff (rst)
		fetch_valid |-> fetch.pc == exp_fetch_pc)
		else note_failure($sformatf("fetch pc %h, expected %h", fetch.pc, exp_fetch_pc));

	a_fetch_inst: assert property (@(posedge clk) disable iff (rst)
		fetch_valid |-> fetch.inst == code_word(fetch.pc))
		else note_failure($sformatf("fetch inst %h at pc %h", fetch.inst, fetch.pc));

	// both in-flight fetches are dropped
	a_redirect_drop: assert property (@(posedge clk) disable iff (rst)
		redirect_valid |=> !fetch_valid [*2])
		else note_failure("old fetch delivered after redirect");

	a_mul_on_time: assert property (@(posedge clk) disable iff (rst)
		mul_done |-> mul_pending && mul_age == mul_lat)
		else note_failure($sformatf("mul_done after %0d cycles, expected %0d", mul_age, mul_lat));

	a_mul_not_late: assert property (@(posedge clk) disable iff (rst)
		mul_pending && mul_age == mul_lat && !mul_flush |-> mul_done)
		else note_failure("mul_done missing at expected latency");

	a_mul_result: assert property (@(posedge clk) disable iff (rst)
		mul_done |-> mul_rsp == exp_mul_rsp)
		else note_failure($sformatf("mul result %h, expected %h", mul_rsp, exp_mul_rsp));

	// ********************
	// run control
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'hf051));
		rst            = 1'b1;
		fetch_en       = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		lsu_req_valid  = 1'b0;
		lsu_req        = '0;
		mul_start      = 1'b0;
		mul_flush      = 1'b0;
		mul_req        = '0;
		exp_lsu_rdata  = '0;
		exp_mul_rsp    = '0;
		err_cnt        = 0;
		test_cnt       = 0;
		lsu_cnt        = 0;
		fetch_cnt      = 0;
		mul_cnt        = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		lsu_size_sweep();
		fetch_sequence();
		arbitration_mix();
		redirect_flow();
		multiply_modes();
		flush_restart();
		repeat (4) @(posedge clk);
		$display("%0d tests, %0d lsu, %0d fetch, %0d mul checked, %0d failures",
			test_cnt, lsu_cnt, fetch_cnt, mul_cnt, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	`include "tb_npc_stim.svh"

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+dv
source/mem_pkg.sv
source/mul_pkg.sv
source/mem_sram.sv
source/mem_arbiter.sv
source/fetch_unit.sv
source/lsu.sv
source/booth_mul.sv
source/npc_mem_top.sv
dv/tb_npc_mem.sv
